/* axi3_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi3_mem_model #(
  parameter int AW_LOG_DEPTH = 128,
  parameter int W_LOG_DEPTH  = 2048
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    random_stall,  // Random gaps on awready and wready
  input  logic                    hold_wready,   // Keep wready low
  input  ram_writer_pkg::axi_aw_t aw,
  input  logic                    awvalid,
  output logic                    awready,
  input  ram_writer_pkg::axi_w_t  w,
  input  logic                    wvalid,
  output logic                    wready
);

  import ram_writer_pkg::*;

  axi_aw_t aw_log [AW_LOG_DEPTH];   // One entry per accepted address
  axi_w_t  w_log [W_LOG_DEPTH];     // Beats in arrival order
  int      aw_count;
  int      w_count;

  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
    end
    else
    begin
      awready <= random_stall ? ($urandom_range(3) != 0) : 1'b1;
      if (hold_wready)
      begin
        wready <= 1'b0;
      end
      else
      begin
        wready <= random_stall ? ($urandom_range(3) != 0) : 1'b1;
      end
    end
  end

  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      aw_count <= 0;
      w_count  <= 0;
    end
    else
    begin
      if (awvalid && awready && aw_count < AW_LOG_DEPTH)
      begin
        aw_log[aw_count] <= aw;
        aw_count         <= aw_count + 1;
      end
      if (wvalid && wready && w_count < W_LOG_DEPTH)
      begin
        w_log[w_count] <= w;
        w_count        <= w_count + 1;
      end
    end
  end

endmodule

`default_nettype wire

/* burst_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 9
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  wr,
  input  ram_writer_pkg::beat_t wr_beat,
  input  logic                  rd,
  output ram_writer_pkg::beat_t rd_beat,
  output logic                  valid,
  output logic                  full,
  output logic                  burst_avail
);

  import ram_writer_pkg::*;

  localparam int DEPTH     = 1 << FIFO_DEPTH_LOG2;
  localparam int LEVEL_W   = FIFO_DEPTH_LOG2 + 1;

  beat_t                      mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr_q;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_q;
  logic [LEVEL_W-1:0]         count_q;
  logic [LEVEL_W-1:0]         level_after_rd;
  logic                       do_wr;
  logic                       do_rd;

  assign do_wr = wr & ~full;
  assign do_rd = rd & valid;

  assign valid = (count_q != '0);
  assign full  = (count_q == LEVEL_W'(DEPTH));

  // Beats left once the current read is gone, so a burst
  // finishing this cycle does not count toward the next one
  assign level_after_rd = count_q - LEVEL_W'(do_rd);
  assign burst_avail    = (level_after_rd >= LEVEL_W'(BURST_BEATS));

  assign rd_beat = mem[rd_ptr_q];              // Fall-through head

  always_ff @(posedge aclk)
  begin
    if (do_wr)
    begin
      mem[wr_ptr_q] <= wr_beat;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_wr)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;           // Wraps at DEPTH
      end
      if (do_rd)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;           // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

/* burst_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_writer #(
  parameter ram_writer_pkg::axi_addr_t ADDR_BASE = 32'h1E000000,
  parameter int BEAT_ADDR_WIDTH = 20
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  ram_writer_pkg::beat_t   fifo_beat,
  input  logic                    fifo_valid,
  input  logic                    burst_avail,
  output logic                    fifo_rd,
  output ram_writer_pkg::axi_aw_t m_axi_aw,
  output logic                    m_axi_awvalid,
  input  logic                    m_axi_awready,
  output ram_writer_pkg::axi_w_t  m_axi_w,
  output logic                    m_axi_wvalid,
  input  logic                    m_axi_wready,
  output logic                    m_axi_bready
);

  import ram_writer_pkg::*;

  localparam int BURST_LOG2 = $clog2(BURST_BEATS);
  localparam int BURST_CNT_W = BEAT_ADDR_WIDTH - BURST_LOG2;

  writer_state_t          state_q, state_d;
  logic                   awvalid_q, awvalid_d;
  logic                   wvalid_q, wvalid_d;
  logic [BURST_LOG2-1:0]  beat_idx_q, beat_idx_d;     // Beat within the burst
  logic [BURST_CNT_W-1:0] burst_cnt_q, burst_cnt_d;   // Burst slot in the region
  axi_id_t                burst_id_q, burst_id_d;

  logic                       aw_fire;
  logic                       w_fire;
  logic                       w_last;
  logic                       aw_done;
  logic [BEAT_ADDR_WIDTH-1:0] beat_addr;
  axi_addr_t                  burst_addr;

  assign aw_fire = m_axi_awvalid & m_axi_awready;
  assign w_fire  = m_axi_wvalid & m_axi_wready;
  assign w_last  = &beat_idx_q;
  assign aw_done = ~awvalid_q | m_axi_awready;        // AW gone by the end of this cycle

  // Beat address of the burst start, wraps with the region
  assign beat_addr  = {burst_cnt_q, {BURST_LOG2{1'b0}}};
  assign burst_addr = ADDR_BASE + (axi_addr_t'(beat_addr) << BEAT_BYTES_LOG2);

  assign fifo_rd = w_fire;

  always_comb
  begin
    state_d     = state_q;
    awvalid_d   = awvalid_q;
    wvalid_d    = wvalid_q;
    beat_idx_d  = beat_idx_q;
    burst_cnt_d = burst_cnt_q;
    burst_id_d  = burst_id_q;

    case (state_q)
      IDLE:
      begin
        if (burst_avail)
        begin
          state_d   = BURST;
          awvalid_d = 1'b1;
          wvalid_d  = 1'b1;
        end
      end

      BURST:
      begin
        if (aw_fire)
        begin
          awvalid_d = 1'b0;
        end
        if (w_fire)
        begin
          beat_idx_d = beat_idx_q + 1'b1;
        end
        if (w_fire && w_last)
        begin
          if (aw_done)
          begin
            burst_cnt_d = burst_cnt_q + 1'b1;
            burst_id_d  = burst_id_q + 1'b1;
            if (burst_avail)
            begin
              awvalid_d = 1'b1;                       // Back-to-back burst
            end
            else
            begin
              wvalid_d = 1'b0;
              state_d  = IDLE;
            end
          end
          else
          begin
            wvalid_d = 1'b0;                          // Data ahead of address
            state_d  = WAIT_AW;
          end
        end
      end

      WAIT_AW:
      begin
        if (aw_fire)
        begin
          awvalid_d   = 1'b0;
          burst_cnt_d = burst_cnt_q + 1'b1;
          burst_id_d  = burst_id_q + 1'b1;
          state_d     = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_q     <= IDLE;
      awvalid_q   <= 1'b0;
      wvalid_q    <= 1'b0;
      beat_idx_q  <= '0;
      burst_cnt_q <= '0;
      burst_id_q  <= '0;
    end
    else
    begin
      state_q     <= state_d;
      awvalid_q   <= awvalid_d;
      wvalid_q    <= wvalid_d;
      beat_idx_q  <= beat_idx_d;
      burst_cnt_q <= burst_cnt_d;
      burst_id_q  <= burst_id_d;
    end
  end

  assign m_axi_awvalid  = awvalid_q;
  assign m_axi_aw.id    = burst_id_q;
  assign m_axi_aw.addr  = burst_addr;
  assign m_axi_aw.len   = 4'(BURST_BEATS - 1);
  assign m_axi_aw.size  = 3'(BEAT_BYTES_LOG2);
  assign m_axi_aw.burst = 2'b01;                       // INCR
  assign m_axi_aw.cache = 4'b0011;                     // Bufferable, modifiable

  assign m_axi_wvalid = wvalid_q & fifo_valid;         // Never present an empty head
  assign m_axi_w.id   = burst_id_q;
  assign m_axi_w.data = fifo_beat;
  assign m_axi_w.strb = '1;
  assign m_axi_w.last = w_last;

  assign m_axi_bready = 1'b1;                          // Responses are dropped

endmodule

`default_nettype wire

/* ram_writer_pkg.sv */
`default_nettype none

package ram_writer_pkg;

  // Fixed datapath widths, two samples per beat
  localparam int SAMPLE_WIDTH    = 32;
  localparam int BEAT_WIDTH      = 64;
  localparam int AXI_ADDR_WIDTH  = 32;
  localparam int AXI_ID_WIDTH    = 6;
  localparam int BURST_BEATS     = 16;
  localparam int BEAT_BYTES_LOG2 = 3;

  typedef logic [SAMPLE_WIDTH-1:0]   sample_t;
  typedef logic [BEAT_WIDTH-1:0]     beat_t;
  typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;

  // AXI3 write address payload
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    logic [3:0] len;    // Beats minus one
    logic [2:0] size;   // Log2 of bytes per beat
    logic [1:0] burst;  // 2'b01 is INCR
    logic [3:0] cache;
  } axi_aw_t;

  // AXI3 write data payload, wid still present in AXI3
  typedef struct packed {
    axi_id_t                 id;
    beat_t                   data;
    logic [BEAT_WIDTH/8-1:0] strb;
    logic                    last;
  } axi_w_t;

  typedef enum logic [1:0] {
    IDLE,     // Waiting for a full burst in the FIFO
    BURST,    // Address and data in flight
    WAIT_AW   // Data done, address still pending
  } writer_state_t;

endpackage

`default_nettype wire

/* ram_writer_top.f */
ram_writer_pkg.sv
sample_packer.sv
burst_fifo.sv
burst_writer.sv
ram_writer_top.sv
axi3_mem_model.sv
tb_ram_writer_top.sv

/* ram_writer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_writer_top #(
  parameter ram_writer_pkg::axi_addr_t ADDR_BASE = 32'h1E000000,
  parameter int BEAT_ADDR_WIDTH = 20,
  parameter int FIFO_DEPTH_LOG2 = 9
) (
  input  logic                    aclk,
  input  logic                    aresetn,

  // Sample stream in
  input  ram_writer_pkg::sample_t s_axis_tdata,
  input  logic                    s_axis_tvalid,
  output logic                    s_axis_tready,

  // AXI3 write master out
  output ram_writer_pkg::axi_aw_t m_axi_aw,
  output logic                    m_axi_awvalid,
  input  logic                    m_axi_awready,
  output ram_writer_pkg::axi_w_t  m_axi_w,
  output logic                    m_axi_wvalid,
  input  logic                    m_axi_wready,
  output logic                    m_axi_bready
);

  import ram_writer_pkg::*;

  beat_t pack_beat;
  logic  pack_wr;
  logic  fifo_full;
  beat_t fifo_beat;
  logic  fifo_valid;
  logic  burst_avail;
  logic  fifo_rd;

  sample_packer u_packer (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_tdata   (s_axis_tdata),
    .s_tvalid  (s_axis_tvalid),
    .fifo_full (fifo_full),
    .s_tready  (s_axis_tready),
    .pack_beat (pack_beat),
    .pack_wr   (pack_wr)
  );

  burst_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_fifo (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .wr          (pack_wr),
    .wr_beat     (pack_beat),
    .rd          (fifo_rd),
    .rd_beat     (fifo_beat),
    .valid       (fifo_valid),
    .full        (fifo_full),
    .burst_avail (burst_avail)
  );

  burst_writer #(
    .ADDR_BASE       (ADDR_BASE),
    .BEAT_ADDR_WIDTH (BEAT_ADDR_WIDTH)
  ) u_writer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .fifo_beat     (fifo_beat),
    .fifo_valid    (fifo_valid),
    .burst_avail   (burst_avail),
    .fifo_rd       (fifo_rd),
    .m_axi_aw      (m_axi_aw),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_w       (m_axi_w),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bready  (m_axi_bready)
  );

endmodule

`default_nettype wire

/* sample_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_packer (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  ram_writer_pkg::sample_t s_tdata,
  input  logic                    s_tvalid,
  input  logic                    fifo_full,
  output logic                    s_tready,
  output ram_writer_pkg::beat_t   pack_beat,
  output logic                    pack_wr
);

  import ram_writer_pkg::*;

  logic    accept;
  logic    phase_q;   // High while the low half is held
  sample_t held_q;    // First sample of the current pair

  assign s_tready = ~fifo_full;                // Stall the stream when the FIFO is full
  assign accept   = s_tvalid & s_tready;

  // Second sample completes the beat in the same cycle
  assign pack_wr   = accept & phase_q;
  assign pack_beat = {s_tdata, held_q};        // Later sample goes high

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      phase_q <= 1'b0;
    end
    else if (accept)
    begin
      phase_q <= ~phase_q;                     // Toggle only on real transfers
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept && !phase_q)
    begin
      held_q <= s_tdata;
    end
  end

endmodule

`default_nettype wire

/* tb_ram_writer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ram_writer_top;

  import ram_writer_pkg::*;

  localparam axi_addr_t ADDR_BASE       = 32'h1E000000;
  localparam int        BEAT_ADDR_WIDTH = 7;
  localparam int        FIFO_DEPTH_LOG2 = 5;
  localparam int        REGION_BURSTS   = (1 << BEAT_ADDR_WIDTH) / BURST_BEATS;
  localparam int        BURST_BYTES     = BURST_BEATS * 8;
  localparam int        DRAIN_TIMEOUT   = 20000;

  logic    aclk;
  logic    aresetn;
  sample_t s_axis_tdata;
  logic    s_axis_tvalid;
  logic    s_axis_tready;
  axi_aw_t m_axi_aw;
  logic    m_axi_awvalid;
  logic    m_axi_awready;
  axi_w_t  m_axi_w;
  logic    m_axi_wvalid;
  logic    m_axi_wready;
  logic    m_axi_bready;
  logic    random_stall;
  logic    hold_wready;
  int      sample_cnt;   // Next sample value, also the count accepted so far
  int      aw_checked;
  int      w_checked;
  int      sent;

  ram_writer_top #(
    .ADDR_BASE       (ADDR_BASE),
    .BEAT_ADDR_WIDTH (BEAT_ADDR_WIDTH),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_dut (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axi_aw      (m_axi_aw),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_w       (m_axi_w),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bready  (m_axi_bready)
  );

  axi3_mem_model u_mem (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .random_stall (random_stall),
    .hold_wready  (hold_wready),
    .aw           (m_axi_aw),
    .awvalid      (m_axi_awvalid),
    .awready      (m_axi_awready),
    .w            (m_axi_w),
    .wvalid       (m_axi_wvalid),
    .wready       (m_axi_wready)
  );

  initial
  begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [63:0] exp, input logic [63:0] act);
    abort_run($sformatf("mismatch %s %s: expected %0h actual %0h", test, what, exp, act));
  endtask

  task automatic check_idle(input string test);
    assert (m_axi_awvalid == 1'b0) else report_mismatch(test, "awvalid", 0, m_axi_awvalid);
    assert (m_axi_wvalid == 1'b0) else report_mismatch(test, "wvalid", 0, m_axi_wvalid);
    assert (s_axis_tready == 1'b1) else report_mismatch(test, "tready", 1, s_axis_tready);
    assert (m_axi_bready == 1'b1) else report_mismatch(test, "bready", 1, m_axi_bready);
  endtask

  // Offers counter samples until n are accepted or max_cycles run out
  task automatic drive_stream(input int n, input bit gaps, input int max_cycles,
                              output int accepted);
    int cycles;
    accepted = 0;
    cycles   = 0;
    while (accepted < n && cycles < max_cycles)
    begin
      @(posedge aclk);
      cycles++;
      if (s_axis_tvalid && s_axis_tready)
      begin
        accepted++;
        sample_cnt++;
      end
      s_axis_tdata  <= sample_t'(sample_cnt);
      s_axis_tvalid <= (accepted < n) && (!gaps || $urandom_range(3) != 0);
    end
    s_axis_tvalid <= 1'b0;
  endtask

  task automatic watch_quiet(input string test, input int cycles);
    repeat (cycles)
    begin
      @(negedge aclk);
      assert (m_axi_awvalid == 1'b0) else report_mismatch(test, "awvalid", 0, m_axi_awvalid);
    end
  endtask

  task automatic wait_for_beats(input string test, input int beats);
    int cycles;
    cycles = 0;
    while ((u_mem.w_count < beats || u_mem.aw_count < beats / BURST_BEATS)
           && cycles < DRAIN_TIMEOUT)
    begin
      @(negedge aclk);
      cycles++;
    end
    if (u_mem.w_count < beats || u_mem.aw_count < beats / BURST_BEATS)
    begin
      abort_run($sformatf("%s: timed out waiting for %0d beats in memory", test, beats));
    end
  endtask

  // Beat k holds samples 2k and 2k+1, burst n has ID n mod 64 and wraps every 8 slots
  task automatic check_log(input string test, input int beats);
    int        k;
    int        n;
    beat_t     exp_data;
    axi_addr_t exp_addr;
    assert (u_mem.w_count == beats) else report_mismatch(test, "beats", beats, u_mem.w_count);
    assert (u_mem.aw_count == beats / BURST_BEATS)
      else report_mismatch(test, "bursts", beats / BURST_BEATS, u_mem.aw_count);
    for (k = w_checked; k < beats; k++)
    begin
      n        = k / BURST_BEATS;
      exp_data = {sample_t'(2 * k + 1), sample_t'(2 * k)};
      assert (u_mem.w_log[k].data == exp_data)
        else report_mismatch(test, $sformatf("beat %0d data", k), exp_data, u_mem.w_log[k].data);
      assert (u_mem.w_log[k].last == (k % BURST_BEATS == BURST_BEATS - 1))
        else report_mismatch(test, $sformatf("beat %0d last", k),
                             (k % BURST_BEATS == BURST_BEATS - 1), u_mem.w_log[k].last);
      assert (u_mem.w_log[k].strb == 8'hff)
        else report_mismatch(test, $sformatf("beat %0d strb", k), 8'hff, u_mem.w_log[k].strb);
      assert (u_mem.w_log[k].id == axi_id_t'(n % 64))
        else report_mismatch(test, $sformatf("beat %0d id", k), n % 64, u_mem.w_log[k].id);
    end
    for (n = aw_checked; n < beats / BURST_BEATS; n++)
    begin
      exp_addr = ADDR_BASE + axi_addr_t'(BURST_BYTES * (n % REGION_BURSTS));
      assert (u_mem.aw_log[n].addr == exp_addr)
        else report_mismatch(test, $sformatf("burst %0d addr", n), exp_addr, u_mem.aw_log[n].addr);
      assert (u_mem.aw_log[n].id == axi_id_t'(n % 64))
        else report_mismatch(test, $sformatf("burst %0d id", n), n % 64, u_mem.aw_log[n].id);
      assert (u_mem.aw_log[n].len == 4'd15)
        else report_mismatch(test, $sformatf("burst %0d len", n), 15, u_mem.aw_log[n].len);
      assert (u_mem.aw_log[n].size == 3'd3)
        else report_mismatch(test, $sformatf("burst %0d size", n), 3, u_mem.aw_log[n].size);
      assert (u_mem.aw_log[n].burst == 2'b01)
        else report_mismatch(test, $sformatf("burst %0d type", n), 1, u_mem.aw_log[n].burst);
      assert (u_mem.aw_log[n].cache == 4'd3)
        else report_mismatch(test, $sformatf("burst %0d cache", n), 3, u_mem.aw_log[n].cache);
    end
    w_checked  = beats;
    aw_checked = beats / BURST_BEATS;
  endtask

  initial
  begin
    void'($urandom(32'hf04d));
    aresetn       = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    random_stall  = 1'b0;
    hold_wready   = 1'b0;
    sample_cnt    = 0;
    aw_checked    = 0;
    w_checked     = 0;

    repeat (16)
    begin
      @(negedge aclk);
      check_idle("reset");
    end
    @(posedge aclk);
    aresetn <= 1'b1;
    repeat (4)
    begin
      @(negedge aclk);
      check_idle("after reset");
    end

    // Ten beats buffered must not start a burst
    drive_stream(20, 1'b1, 2000, sent);
    assert (sent == 20) else report_mismatch("partial", "accepted samples", 20, sent);
    watch_quiet("partial", 200);
    drive_stream(12, 1'b1, 2000, sent);
    assert (sent == 12) else report_mismatch("partial", "accepted samples", 12, sent);
    wait_for_beats("partial", 16);
    watch_quiet("partial", 50);
    check_log("partial", 16);

    // FIFO of 32 beats fills while wready is held low
    @(posedge aclk);
    hold_wready <= 1'b1;
    drive_stream(1000, 1'b0, 300, sent);
    assert (sent == 64) else report_mismatch("backpressure", "accepted samples", 64, sent);
    assert (s_axis_tready == 1'b0)
      else report_mismatch("backpressure", "tready", 0, s_axis_tready);
    hold_wready <= 1'b0;
    wait_for_beats("backpressure", 48);
    check_log("backpressure", 48);

    @(posedge aclk);
    random_stall <= 1'b1;
    drive_stream(256, 1'b1, 256 * 20, sent);
    assert (sent == 256) else report_mismatch("random stalls", "accepted samples", 256, sent);
    wait_for_beats("random stalls", 176);
    check_log("random stalls", 176);

    // Long run past 64 bursts so the ID rolls over
    drive_stream(2048, 1'b1, 2048 * 20, sent);
    assert (sent == 2048) else report_mismatch("id wrap", "accepted samples", 2048, sent);
    wait_for_beats("id wrap", 1200);
    check_log("id wrap", 1200);

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
